// File: source/vec_pkg.sv
package vec_pkg;

   // lane geometry
   localparam int V_LANES       = 4;
   localparam int ELEM_W        = 32;
   localparam int NUM_VREGS     = 8;
   localparam int ROWS_PER_LANE = 8;
   localparam int MAX_VL        = V_LANES * ROWS_PER_LANE;

   // host port
   localparam int AXI_ADDR_W = 5;

   // derived field widths
   localparam int LANE_W  = $clog2(V_LANES);
   localparam int ROW_W   = $clog2(ROWS_PER_LANE);
   localparam int REG_W   = $clog2(NUM_VREGS);
   localparam int VL_W    = $clog2(MAX_VL + 1);
   localparam int EADDR_W = 11;

   // element-wise operations, vs1 op vs2
   typedef enum logic [2:0] {
      VOP_ADD = 3'd0,
      VOP_SUB = 3'd1,
      VOP_AND = 3'd2,
      VOP_OR  = 3'd3,
      VOP_XOR = 3'd4,
      // shift amount is the low 5 bits of vs2
      VOP_SLL = 3'd5
   } vop_e;

   // register byte offsets
   localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 5'h00;
   localparam logic [AXI_ADDR_W-1:0] REG_VL     = 5'h04;
   localparam logic [AXI_ADDR_W-1:0] REG_EADDR  = 5'h08;
   localparam logic [AXI_ADDR_W-1:0] REG_EDATA  = 5'h0C;
   localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 5'h10;

   // response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: source/vec_axil_dispatch.sv
`timescale 1ns/1ns

module vec_axil_dispatch (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           awvalid,
   input  logic [vec_pkg::AXI_ADDR_W-1:0] awaddr,
   output logic                           awready,
   input  logic                           wvalid,
   input  logic [31:0]                    wdata,
   output logic                           wready,
   output logic                           bvalid,
   input  logic                           bready,
   output logic [1:0]                     bresp,
   input  logic                           any_busy,
   output logic [vec_pkg::EADDR_W-1:0]    eaddr,
   output logic                           wr_en,
   output logic [vec_pkg::V_LANES-1:0]    wr_lane_sel,
   output logic [vec_pkg::REG_W-1:0]      wr_reg,
   output logic [vec_pkg::ROW_W-1:0]      wr_row,
   output logic [vec_pkg::ELEM_W-1:0]     wr_data,
   output logic                           start,
   output vec_pkg::vop_e                  op,
   output logic [vec_pkg::REG_W-1:0]      vd,
   output logic [vec_pkg::REG_W-1:0]      vs1,
   output logic [vec_pkg::REG_W-1:0]      vs2,
   output logic [vec_pkg::VL_W-1:0]       vl
);
   import vec_pkg::*;

   logic accept;
   logic bad;
   logic wr_elem;

   // address and data are taken together, never while a lane is working
   assign accept  = awvalid && wvalid && !bvalid && !any_busy;
   assign awready = accept;
   assign wready  = accept;

   always_comb
   begin
      case (awaddr)
         REG_CTRL:  bad = (wdata[2:0] > VOP_SLL);
         REG_VL:    bad = (wdata > MAX_VL);
         REG_EADDR: bad = 1'b0;
         REG_EDATA: bad = 1'b0;
         // status is read only
         default:   bad = 1'b1;
      endcase
   end

   assign wr_elem = accept && (awaddr == REG_EDATA);

   // op start goes out in the accept cycle so busy rises one cycle later
   assign start = accept && (awaddr == REG_CTRL) && !bad;
   assign op    = vop_e'(wdata[2:0]);
   assign vd    = wdata[6:4];
   assign vs1   = wdata[10:8];
   assign vs2   = wdata[14:12];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bvalid <= 1'b0;
         bresp  <= RESP_OKAY;
         vl     <= '0;
         eaddr  <= '0;
         wr_en  <= 1'b0;
      end
      else
      begin
         wr_en <= wr_elem;
         if (accept)
         begin
            bvalid <= 1'b1;
            bresp  <= bad ? RESP_SLVERR : RESP_OKAY;
            if (!bad && (awaddr == REG_VL))
            begin
               vl <= wdata[VL_W-1:0];
            end
            if (!bad && (awaddr == REG_EADDR))
            begin
               // register number and element index only
               eaddr <= {wdata[10:8], 3'b000, wdata[4:0]};
            end
         end
         else if (bready)
         begin
            bvalid <= 1'b0;
         end
      end
   end

   // element index splits into lane (low bits) and row (high bits)
   always_ff @(posedge clk)
   begin
      if (wr_elem)
      begin
         wr_lane_sel <= V_LANES'(1) << eaddr[LANE_W-1:0];
         wr_reg      <= eaddr[10:8];
         wr_row      <= eaddr[LANE_W +: ROW_W];
         wr_data     <= wdata;
      end
   end

   // write response and its code stay put until the host takes them
   assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// File: source/vec_lane.sv
`timescale 1ns/1ns

module vec_lane #(
   parameter int LANE_ID = 0
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         wr_en,
   input  logic [vec_pkg::V_LANES-1:0]  wr_lane_sel,
   input  logic [vec_pkg::REG_W-1:0]    wr_reg,
   input  logic [vec_pkg::ROW_W-1:0]    wr_row,
   input  logic [vec_pkg::ELEM_W-1:0]   wr_data,
   input  logic                         start,
   input  vec_pkg::vop_e                op,
   input  logic [vec_pkg::REG_W-1:0]    vd,
   input  logic [vec_pkg::REG_W-1:0]    vs1,
   input  logic [vec_pkg::REG_W-1:0]    vs2,
   input  logic [vec_pkg::VL_W-1:0]     vl,
   input  logic [vec_pkg::REG_W-1:0]    rd_reg,
   input  logic [vec_pkg::ROW_W-1:0]    rd_row,
   output logic [vec_pkg::ELEM_W-1:0]   rd_data,
   output logic                         busy
);
   import vec_pkg::*;

   // this lane's slice, element e at row e / V_LANES
   logic [ELEM_W-1:0] vrf [NUM_VREGS][ROWS_PER_LANE];

   vop_e              op_q;
   logic [REG_W-1:0]  vd_q;
   logic [REG_W-1:0]  vs1_q;
   logic [REG_W-1:0]  vs2_q;
   logic [VL_W-1:0]   vl_q;
   logic [ROW_W-1:0]  row_q;
   logic [VL_W-1:0]   vl_m1;
   logic [ROW_W-1:0]  last_row;
   logic [VL_W-1:0]   elem_idx;
   logic [ELEM_W-1:0] src_a;
   logic [ELEM_W-1:0] src_b;
   logic [ELEM_W-1:0] result;

   assign rd_data  = vrf[rd_reg][rd_row];
   assign src_a    = vrf[vs1_q][row_q];
   assign src_b    = vrf[vs2_q][row_q];
   assign vl_m1    = vl_q - 1'b1;
   // all lanes step the same number of rows
   assign last_row = vl_m1[LANE_W +: ROW_W];
   assign elem_idx = VL_W'(row_q * V_LANES + LANE_ID);

   always_comb
   begin
      case (op_q)
         VOP_ADD: result = src_a + src_b;
         VOP_SUB: result = src_a - src_b;
         VOP_AND: result = src_a & src_b;
         VOP_OR:  result = src_a | src_b;
         VOP_XOR: result = src_a ^ src_b;
         VOP_SLL: result = src_a << src_b[4:0];
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         op_q  <= op;
         vd_q  <= vd;
         vs1_q <= vs1;
         vs2_q <= vs2;
         vl_q  <= vl;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy  <= 1'b0;
         row_q <= '0;
         for (int r = 0; r < NUM_VREGS; r++)
         begin
            for (int w = 0; w < ROWS_PER_LANE; w++)
            begin
               vrf[r][w] <= '0;
            end
         end
      end
      else
      begin
         if (start)
         begin
            // zero length finishes at once
            busy  <= (vl != '0);
            row_q <= '0;
         end
         else if (busy)
         begin
            // tail elements past vl keep their old value
            if (elem_idx < vl_q)
            begin
               vrf[vd_q][row_q] <= result;
            end
            if (row_q == last_row)
            begin
               busy <= 1'b0;
            end
            else
            begin
               row_q <= row_q + 1'b1;
            end
         end
         if (wr_en && wr_lane_sel[LANE_ID])
         begin
            vrf[wr_reg][wr_row] <= wr_data;
         end
      end
   end

   // the dispatcher holds off the host while any lane runs
   assert property (@(posedge clk) disable iff (reset) busy |-> !start);
   assert property (@(posedge clk) disable iff (reset) busy |-> !wr_en);

endmodule

// File: source/vec_readback.sv
`timescale 1ns/1ns

module vec_readback (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    arvalid,
   input  logic [vec_pkg::AXI_ADDR_W-1:0]          araddr,
   output logic                                    arready,
   output logic                                    rvalid,
   input  logic                                    rready,
   output logic [31:0]                             rdata,
   output logic [1:0]                              rresp,
   input  logic [vec_pkg::EADDR_W-1:0]             eaddr,
   input  logic [vec_pkg::V_LANES*vec_pkg::ELEM_W-1:0] lane_rd_data,
   input  logic                                    any_busy,
   output logic [vec_pkg::REG_W-1:0]               rd_reg,
   output logic [vec_pkg::ROW_W-1:0]               rd_row
);
   import vec_pkg::*;

   logic [LANE_W-1:0] lane_sel;
   logic [ELEM_W-1:0] elem;

   assign rd_reg   = eaddr[10:8];
   assign rd_row   = eaddr[LANE_W +: ROW_W];
   assign lane_sel = eaddr[LANE_W-1:0];
   assign elem     = lane_rd_data[lane_sel*ELEM_W +: ELEM_W];
   // one read outstanding at a time
   assign arready  = !rvalid;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rvalid <= 1'b0;
      end
      else if (arvalid && arready)
      begin
         rvalid <= 1'b1;
      end
      else if (rready)
      begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (arvalid && arready)
      begin
         rresp <= RESP_OKAY;
         case (araddr)
            REG_EDATA:  rdata <= elem;
            REG_STATUS: rdata <= {31'b0, any_busy};
            REG_EADDR:  rdata <= 32'(eaddr);
            default:
            begin
               // ctrl and vl are write only
               rdata <= '0;
               rresp <= RESP_SLVERR;
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: source/vec_unit_top.sv
`timescale 1ns/1ns

module vec_unit_top (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           awvalid,
   output logic                           awready,
   input  logic [vec_pkg::AXI_ADDR_W-1:0] awaddr,
   input  logic                           wvalid,
   output logic                           wready,
   input  logic [31:0]                    wdata,
   output logic                           bvalid,
   input  logic                           bready,
   output logic [1:0]                     bresp,
   input  logic                           arvalid,
   output logic                           arready,
   input  logic [vec_pkg::AXI_ADDR_W-1:0] araddr,
   output logic                           rvalid,
   input  logic                           rready,
   output logic [31:0]                    rdata,
   output logic [1:0]                     rresp
);
   import vec_pkg::*;

   logic                      any_busy;
   logic [V_LANES-1:0]        lane_busy;
   logic [EADDR_W-1:0]        eaddr;
   logic                      wr_en;
   logic [V_LANES-1:0]        wr_lane_sel;
   logic [REG_W-1:0]          wr_reg;
   logic [ROW_W-1:0]          wr_row;
   logic [ELEM_W-1:0]         wr_data;
   logic                      start;
   vop_e                      op;
   logic [REG_W-1:0]          vd;
   logic [REG_W-1:0]          vs1;
   logic [REG_W-1:0]          vs2;
   logic [VL_W-1:0]           vl;
   logic [REG_W-1:0]          rd_reg;
   logic [ROW_W-1:0]          rd_row;
   logic [V_LANES*ELEM_W-1:0] lane_rd_data;

   assign any_busy = |lane_busy;

   vec_axil_dispatch vec_axil_dispatch_i (
      .clk(clk), .reset(reset),
      .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
      .wvalid(wvalid), .wdata(wdata), .wready(wready),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .any_busy(any_busy), .eaddr(eaddr),
      .wr_en(wr_en), .wr_lane_sel(wr_lane_sel), .wr_reg(wr_reg),
      .wr_row(wr_row), .wr_data(wr_data),
      .start(start), .op(op), .vd(vd), .vs1(vs1), .vs2(vs2), .vl(vl)
   );

   // lane g owns elements g, g + V_LANES, ...
   for (genvar g = 0; g < V_LANES; g++)
   begin : lane_g
      vec_lane #(.LANE_ID(g)) vec_lane_i (
         .clk(clk), .reset(reset),
         .wr_en(wr_en), .wr_lane_sel(wr_lane_sel), .wr_reg(wr_reg),
         .wr_row(wr_row), .wr_data(wr_data),
         .start(start), .op(op), .vd(vd), .vs1(vs1), .vs2(vs2), .vl(vl),
         .rd_reg(rd_reg), .rd_row(rd_row),
         .rd_data(lane_rd_data[g*ELEM_W +: ELEM_W]),
         .busy(lane_busy[g])
      );
   end

   vec_readback vec_readback_i (
      .clk(clk), .reset(reset),
      .arvalid(arvalid), .araddr(araddr), .arready(arready),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
      .eaddr(eaddr), .lane_rd_data(lane_rd_data), .any_busy(any_busy),
      .rd_reg(rd_reg), .rd_row(rd_row)
   );

endmodule

// File: tb/vec_unit_tb.sv
`timescale 1ns/1ns

module vec_unit_tb;
   import vec_pkg::*;

   localparam int TIMEOUT  = 100;
   localparam int POLL_MAX = 50;
   localparam int NCASE    = 7;

   logic        clk;
   logic        reset;
   logic        awvalid;
   logic        awready;
   logic [4:0]  awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [4:0]  araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;

   integer      seed = 62;
   logic [31:0] model [NUM_VREGS][MAX_VL];
   int          cur_vl;

   // one row per case: name, op, vd, vs1, vs2, vl
   string      case_name [NCASE] = '{"add_vl32", "sub_vl13", "and_vl3", "or_vl32_vd_is_vs1",
                                     "xor_vl0", "sll_vl13", "sll_vl32_vd_is_vs1"};
   logic [2:0] case_op   [NCASE] = '{VOP_ADD, VOP_SUB, VOP_AND, VOP_OR, VOP_XOR, VOP_SLL,
                                     VOP_SLL};
   int         case_vd   [NCASE] = '{1, 4, 7, 2, 5, 3, 6};
   int         case_vs1  [NCASE] = '{2, 5, 0, 2, 6, 1, 6};
   int         case_vs2  [NCASE] = '{3, 6, 1, 3, 7, 4, 2};
   int         case_vl   [NCASE] = '{32, 13, 3, 32, 0, 13, 32};

   vec_unit_top vec_unit_top_i (
      .clk(clk), .reset(reset),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
   );

   always #10 clk = ~clk;

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
         fail_now("first mismatch stops the run");
      end
   endtask

   // element-wise rule, vs1 op vs2
   function automatic logic [31:0] apply_op(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
      case (op)
         VOP_ADD: return a + b;
         VOP_SUB: return a - b;
         VOP_AND: return a & b;
         VOP_OR:  return a | b;
         VOP_XOR: return a ^ b;
         default: return a << b[4:0];
      endcase
   endfunction

   // stall counts the cycles with awready low
   task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp, output int stall);
      int n;
      stall = 0;
      n = 0;
      @(negedge clk);
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = addr;
      wdata   = data;
      #1;
      while (!(awready && wready))
      begin
         stall++;
         if (stall > TIMEOUT)
            fail_now("timeout: write address and data were never accepted");
         else
         begin
            @(negedge clk);
            #1;
         end
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid)
      begin
         n++;
         if (n > TIMEOUT)
            fail_now("timeout: no write response arrived");
         else
            @(negedge clk);
      end
      resp   = bresp;
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
   endtask

   // rready stays low for hold cycles while the response must not move
   task automatic axil_read(input logic [4:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
      int n;
      n = 0;
      @(negedge clk);
      arvalid = 1'b1;
      araddr  = addr;
      #1;
      while (!arready)
      begin
         n++;
         if (n > TIMEOUT)
            fail_now("timeout: read address was never accepted");
         else
         begin
            @(negedge clk);
            #1;
         end
      end
      @(negedge clk);
      arvalid = 1'b0;
      n = 0;
      while (!rvalid)
      begin
         n++;
         if (n > TIMEOUT)
            fail_now("timeout: no read data arrived");
         else
            @(negedge clk);
      end
      data = rdata;
      resp = rresp;
      for (int i = 0; i < hold; i++)
      begin
         @(negedge clk);
         check_value("rvalid held under back-pressure", 1, rvalid);
         check_value("rdata held under back-pressure", data, rdata);
      end
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic write_elem(input int r, input int e, input logic [31:0] data);
      logic [1:0] resp;
      int         stall;
      axil_write(REG_EADDR, (r << 8) | e, resp, stall);
      check_value("eaddr write resp", RESP_OKAY, resp);
      axil_write(REG_EDATA, data, resp, stall);
      check_value("edata write resp", RESP_OKAY, resp);
      model[r][e] = data;
   endtask

   task automatic read_elem(input int r, input int e, input int hold,
                            output logic [31:0] data);
      logic [1:0] resp;
      int         stall;
      axil_write(REG_EADDR, (r << 8) | e, resp, stall);
      check_value("eaddr write resp", RESP_OKAY, resp);
      axil_read(REG_EDATA, hold, data, resp);
      check_value("edata read resp", RESP_OKAY, resp);
   endtask

   task automatic verify_reg(input string name, input int r);
      logic [31:0] got;
      for (int e = 0; e < MAX_VL; e++)
      begin
         read_elem(r, e, 0, got);
         check_value($sformatf("%s v%0d[%0d]", name, r, e), model[r][e], got);
      end
   endtask

   task automatic wait_idle(input string name);
      logic [31:0] stat;
      logic [1:0]  resp;
      for (int n = 0; n < POLL_MAX; n++)
      begin
         axil_read(REG_STATUS, 0, stat, resp);
         check_value({name, " status resp"}, RESP_OKAY, resp);
         if (stat[0] == 1'b0)
            return;
      end
      fail_now({"timeout: busy never cleared in ", name});
   endtask

   task automatic run_case(input string name, input logic [2:0] op, input int vd,
                           input int vs1, input int vs2, input int vl,
                           input bit set_vl);
      logic [1:0]  resp;
      logic [31:0] stat;
      int          stall;
      // background first, so a shared vd and vs1 ends up random
      for (int e = 0; e < MAX_VL; e++)
         write_elem(vd, e, 32'hb000_0000 | (vd << 8) | e);
      for (int e = 0; e < MAX_VL; e++)
      begin
         write_elem(vs1, e, $random(seed));
         write_elem(vs2, e, $random(seed));
      end
      if (set_vl)
      begin
         axil_write(REG_VL, vl, resp, stall);
         check_value({name, " vl resp"}, RESP_OKAY, resp);
         cur_vl = vl;
      end
      axil_write(REG_CTRL, op | (vd << 4) | (vs1 << 8) | (vs2 << 12), resp, stall);
      check_value({name, " ctrl resp"}, RESP_OKAY, resp);
      // a full-length op runs 8 rows, long enough to block the next write
      if (vl == MAX_VL && vd != vs1)
      begin
         axil_write(REG_EADDR, 0, resp, stall);
         check_value({name, " write stalled while busy"}, 1, stall > 0);
         check_value({name, " stalled write resp"}, RESP_OKAY, resp);
         axil_read(REG_STATUS, 0, stat, resp);
         check_value({name, " idle after stalled write"}, 0, stat);
      end
      else if (vl == MAX_VL)
      begin
         // busy falls during the hold, the captured status must not follow it
         axil_read(REG_STATUS, ROWS_PER_LANE + 2, stat, resp);
         check_value({name, " status while busy"}, 1, stat);
      end
      wait_idle(name);
      for (int e = 0; e < vl; e++)
         model[vd][e] = apply_op(op, model[vs1][e], model[vs2][e]);
      verify_reg(name, vd);
   endtask

   initial
   begin
      logic [31:0] got;
      logic [1:0]  resp;
      int          stall;
      clk     = 1'b0;
      reset   = 1'b1;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      cur_vl  = 0;
      for (int r = 0; r < NUM_VREGS; r++)
         for (int e = 0; e < MAX_VL; e++)
            model[r][e] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      check_value("arready after reset", 1, arready);
      axil_read(REG_STATUS, 0, got, resp);
      check_value("status after reset", 0, got);
      axil_read(REG_EADDR, 0, got, resp);
      check_value("eaddr after reset", 0, got);
      axil_write(REG_EADDR, 0, resp, stall);
      check_value("first write resp", RESP_OKAY, resp);

      // every index once, spread over the registers
      for (int e = 0; e < MAX_VL; e++)
         write_elem(e % NUM_VREGS, e, $random(seed));
      for (int e = 0; e < MAX_VL; e++)
      begin
         read_elem(e % NUM_VREGS, e, e % 4, got);
         check_value($sformatf("round trip %0d", e), model[e % NUM_VREGS][e], got);
      end

      for (int i = 0; i < NCASE; i++)
         run_case(case_name[i], case_op[i], case_vd[i], case_vs1[i], case_vs2[i],
                  case_vl[i], 1'b1);

      // rejected writes
      axil_write(REG_EADDR, 32'h305, resp, stall);
      check_value("eaddr set resp", RESP_OKAY, resp);
      axil_write(REG_STATUS, 1, resp, stall);
      check_value("status write resp", RESP_SLVERR, resp);
      axil_write(5'h14, 32'h1234, resp, stall);
      check_value("unknown write resp", RESP_SLVERR, resp);
      axil_write(REG_CTRL, 6 | (1 << 4) | (2 << 8) | (3 << 12), resp, stall);
      check_value("illegal op resp", RESP_SLVERR, resp);
      axil_read(REG_STATUS, 0, got, resp);
      check_value("no start on illegal op", 0, got);
      axil_write(REG_VL, MAX_VL + 1, resp, stall);
      check_value("vl too large resp", RESP_SLVERR, resp);
      axil_read(REG_EADDR, 2, got, resp);
      check_value("eaddr kept", 32'h305, got);
      axil_read(5'h14, 0, got, resp);
      check_value("unknown read resp", RESP_SLVERR, resp);
      check_value("unknown read data", 0, got);
      axil_read(REG_CTRL, 0, got, resp);
      check_value("ctrl read resp", RESP_SLVERR, resp);
      check_value("ctrl read data", 0, got);
      verify_reg("after illegal op", 1);
      // vl from the last good write must still apply
      run_case("vl_kept", VOP_ADD, 0, 5, 7, cur_vl, 1'b0);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: src.f
source/vec_pkg.sv
source/vec_axil_dispatch.sv
source/vec_lane.sv
source/vec_readback.sv
source/vec_unit_top.sv
tb/vec_unit_tb.sv
